//--- build.f
+incdir+hdl
hdl/ccip_pkg.sv
hdl/line_fifo.sv
hdl/dma_copy_engine.sv
hdl/mmio_csr.sv
hdl/ccip_split_mmio.sv
hdl/afu_top.sv
verif/host_mem_model.sv
verif/tb_afu_top.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_afu_top
FILELIST = build.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tb_afu_top.sv
/* Testbench of the copy AFU: drives MMIO on the falling edge, runs copies against the
   host model and checks CSR reads, copied data and the busy and zero-line cases. */
`timescale 1ns/1ps
`default_nettype none

`include "ccip_macros.svh"

module tb_afu_top;

    logic                         clk;
    logic                         rst_n;
    ccip_pkg::c0_rx_t             mmio_c0;
    ccip_pkg::ccip_rx_t           fiu_rx;
    ccip_pkg::ccip_tx_t           fiu_tx;
    logic [`CCIP_LINE_ADDR_W-1:0] win_src;
    logic [`CCIP_LINE_ADDR_W-1:0] win_dst;
    logic [`CCIP_MDATA_W-1:0]     win_lines;
    int                           rd_count;
    int                           wr_count;
    logic                         proto_err;
    logic [31:0]                  lfsr;
    logic [`CCIP_DATA_W-1:0]      exp_line [64];

    afu_top afu_top_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .fiu_rx (fiu_rx),
        .fiu_tx (fiu_tx)
    );

    host_mem_model host_mem_model_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .mmio_c0   (mmio_c0),
        .fiu_tx    (fiu_tx),
        .fiu_rx    (fiu_rx),
        .win_src   (win_src),
        .win_dst   (win_dst),
        .win_lines (win_lines),
        .rd_count  (rd_count),
        .wr_count  (wr_count),
        .proto_err (proto_err)
    );

    always #5 clk = ~clk;

    task automatic fail_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("[FAIL] %s expected %h actual %h", name, exp, act);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic fail_plain(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    // Errors seen by the host model end the run here
    always @(posedge clk)
    begin
        assert (!proto_err) else fail_plain("Protocol violation reported by the host model");
    end

    // Galois LFSR, stepped once per bit taken
    task automatic rand_word(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
        @(negedge clk);
        mmio_c0.mmio_wr_valid = 1'b1;
        mmio_c0.mmio_addr     = addr;
        mmio_c0.data          = data;
        @(posedge clk);
        @(negedge clk);
        mmio_c0.mmio_wr_valid = 1'b0;
    endtask

    // Returns the data and the number of falling edges from the request edge to c2 valid
    task automatic mmio_read(input logic [15:0] addr, input logic [8:0] tid,
                             output logic [63:0] data, output int lat);
        @(negedge clk);
        mmio_c0.mmio_rd_valid = 1'b1;
        mmio_c0.mmio_addr     = addr;
        mmio_c0.tid           = tid;
        @(posedge clk);
        @(negedge clk);
        mmio_c0.mmio_rd_valid = 1'b0;
        lat = 1;
        while (!fiu_tx.c2.valid)
        begin
            if (lat > 20)
            begin
                fail_plain("Timeout waiting for an MMIO read response");
            end
            @(negedge clk);
            lat++;
        end
        assert (fiu_tx.c2.tid == tid) else fail_value("mmio tid", 64'(tid), 64'(fiu_tx.c2.tid));
        data = fiu_tx.c2.data;
    endtask

    task automatic wait_done(input string name);
        logic [63:0] st;
        int          lat;
        int          polls;
        polls = 0;
        mmio_read(`CSR_STATUS, 9'h1ab, st, lat);
        while (!st[1])
        begin
            if (polls > 400)
            begin
                fail_plain("Timeout waiting for the copy done status bit");
            end
            polls++;
            mmio_read(`CSR_STATUS, 9'h1ab, st, lat);
        end
        assert (st[0] == 1'b0) else fail_value(name, 64'h2, st);
    endtask

    task automatic start_copy(input logic [41:0] src, input logic [41:0] dst, input int n);
        logic [63:0] v;
        for (int i = 0; i < n; i++)
        begin
            rand_word(64, v);
            exp_line[i] = v;
            host_mem_model_inst.mem[src + 42'(i)] = v;
        end
        win_src   = src;
        win_dst   = dst;
        win_lines = 16'(n);
        mmio_write(`CSR_SRC, 64'(src));
        mmio_write(`CSR_DST, 64'(dst));
        mmio_write(`CSR_LINES, 64'(n));
        mmio_write(`CSR_CTRL, 64'h1);
    endtask

    task automatic check_lines(input logic [41:0] dst, input int n);
        for (int i = 0; i < n; i++)
        begin
            assert (host_mem_model_inst.mem.exists(dst + 42'(i)))
                else fail_plain("A destination line was never written");
            assert (host_mem_model_inst.mem[dst + 42'(i)] == exp_line[i])
                else fail_value("copy data", exp_line[i], host_mem_model_inst.mem[dst + 42'(i)]);
        end
    endtask

    initial
    begin
        logic [63:0] v;
        logic [63:0] rd;
        logic [63:0] st;
        int          lat;
        int          rd0;
        int          wr0;
        int          polls;
        clk       = 1'b0;
        rst_n     = 1'b0;
        mmio_c0   = '0;
        win_src   = '0;
        win_dst   = '0;
        win_lines = '0;
        lfsr      = 32'h38b72463;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // AFU ID with exact latency, then an unmapped word
        mmio_read(`CSR_AFU_ID, 9'h05a, rd, lat);
        assert (rd == `AFU_ID_VALUE) else fail_value("afu id", `AFU_ID_VALUE, rd);
        assert (lat == 2) else fail_value("afu id latency", 64'd2, 64'(lat));
        mmio_read(16'h0040, 9'h033, rd, lat);
        assert (rd == 64'h0) else fail_value("unknown index", 64'h0, rd);

        for (int i = 0; i < 4; i++)
        begin
            rand_word(64, v);
            mmio_write(`CSR_SCRATCH, v);
            mmio_read(`CSR_SCRATCH, 9'(i), rd, lat);
            assert (rd == v) else fail_value("scratch", v, rd);
        end

        // Plain 20-line copy
        start_copy(42'h1000, 42'h2000, 20);
        wait_done("copy status");
        check_lines(42'h2000, 20);

        // A second start during a run must not change its length
        wr0 = wr_count;
        start_copy(42'h3000, 42'h4000, 24);
        polls = 0;
        mmio_read(`CSR_STATUS, 9'h011, st, lat);
        while (!st[0])
        begin
            if (polls > 20)
            begin
                fail_plain("Timeout waiting for the engine to turn busy");
            end
            polls++;
            mmio_read(`CSR_STATUS, 9'h011, st, lat);
        end
        mmio_write(`CSR_LINES, 64'd3);
        mmio_write(`CSR_CTRL, 64'h1);
        wait_done("busy restart status");
        check_lines(42'h4000, 24);
        assert (wr_count - wr0 == 24) else fail_value("ignored start", 64'd24, 64'(wr_count - wr0));

        // Zero-line run must finish without host traffic
        rd0 = rd_count;
        wr0 = wr_count;
        start_copy(42'h5000, 42'h6000, 0);
        wait_done("zero run status");
        assert (rd_count == rd0) else fail_value("zero run reads", 64'(rd0), 64'(rd_count));
        assert (wr_count == wr0) else fail_value("zero run writes", 64'(wr0), 64'(wr_count));

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/host_mem_model.sv
/* FIU and host memory model for the copy AFU testbench: answers line requests after a
   random delay, toggles almost-full at random and flags protocol errors to the top. */
`timescale 1ns/1ps
`default_nettype none

`include "ccip_macros.svh"

module host_mem_model
(
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire ccip_pkg::c0_rx_t              mmio_c0,
    input  wire ccip_pkg::ccip_tx_t            fiu_tx,
    output ccip_pkg::ccip_rx_t                 fiu_rx,
    input  wire logic [`CCIP_LINE_ADDR_W-1:0]  win_src,
    input  wire logic [`CCIP_LINE_ADDR_W-1:0]  win_dst,
    input  wire logic [`CCIP_MDATA_W-1:0]      win_lines,
    output int                                 rd_count,
    output int                                 wr_count,
    output logic                               proto_err
);

    // Host memory, filled and inspected by the top module
    logic [`CCIP_DATA_W-1:0]      mem [logic [`CCIP_LINE_ADDR_W-1:0]];
    bit                           rd_seen [logic [`CCIP_LINE_ADDR_W-1:0]];
    bit                           wr_seen [logic [`CCIP_LINE_ADDR_W-1:0]];

    // Pending responses, each with the cycle from which it may be sent
    logic [`CCIP_LINE_ADDR_W-1:0] rd_addr [$];
    logic [`CCIP_MDATA_W-1:0]     rd_tag [$];
    int                           rd_due [$];
    logic [`CCIP_MDATA_W-1:0]     wr_tag [$];
    int                           wr_due [$];

    ccip_pkg::ccip_rx_t           rx_q;
    logic [`CCIP_LINE_ADDR_W-1:0] sent_addr;
    logic [31:0]                  lfsr;
    int                           cycle;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // One LFSR step per random bit
    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic bit in_window(input logic [`CCIP_LINE_ADDR_W-1:0] a,
                                     input logic [`CCIP_LINE_ADDR_W-1:0] base);
        return (a >= base) && (a < base + `CCIP_LINE_ADDR_W'(win_lines));
    endfunction

    task automatic flag(input string what);
        $display("host model: %s at cycle %0d", what, cycle);
        proto_err <= 1'b1;
    endtask

    initial
    begin
        lfsr      = 32'h38b72463;
        cycle     = 0;
        rd_count  = 0;
        wr_count  = 0;
        proto_err <= 1'b0;
        rx_q      <= '0;
        sent_addr = '0;
    end

    // An MMIO beat from the top module takes c0 over a read response
    always_comb
    begin
        fiu_rx = rx_q;
        if (mmio_c0.mmio_rd_valid || mmio_c0.mmio_wr_valid)
        begin
            fiu_rx.c0 = mmio_c0;
        end
    end

    // Requests are sampled at the rising edge, where the DUT outputs are settled
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (fiu_tx.c0.valid)
        begin
            assert (!rx_q.c0_almfull) else flag("read request while c0 almost-full");
            assert (in_window(fiu_tx.c0.addr, win_src)) else flag("read outside source");
            assert (!rd_seen.exists(fiu_tx.c0.addr)) else flag("line read twice");
            rd_seen[fiu_tx.c0.addr] = 1'b1;
            rd_addr.push_back(fiu_tx.c0.addr);
            rd_tag.push_back(fiu_tx.c0.mdata);
            rd_due.push_back(cycle + 1 + int'(take_bits(3)));
            rd_count = rd_count + 1;
        end
        if (fiu_tx.c1.valid)
        begin
            assert (!rx_q.c1_almfull) else flag("write request while c1 almost-full");
            assert (in_window(fiu_tx.c1.addr, win_dst)) else flag("write outside destination");
            assert (!wr_seen.exists(fiu_tx.c1.addr)) else flag("line written twice");
            // The write tag is the line offset from the destination base
            assert (fiu_tx.c1.mdata == `CCIP_MDATA_W'(fiu_tx.c1.addr - win_dst))
                else flag("write tag does not match its line");
            wr_seen[fiu_tx.c1.addr] = 1'b1;
            mem[fiu_tx.c1.addr] = fiu_tx.c1.data;
            wr_tag.push_back(fiu_tx.c1.mdata);
            wr_due.push_back(cycle + 1 + int'(take_bits(3)));
            wr_count = wr_count + 1;
        end
        // A response hidden behind an MMIO beat was not delivered, so send it again
        if (rx_q.c0.resp_valid && (mmio_c0.mmio_rd_valid || mmio_c0.mmio_wr_valid))
        begin
            rd_addr.push_front(sent_addr);
            rd_tag.push_front(rx_q.c0.mdata);
            rd_due.push_front(cycle);
        end
    end

    // New receive beats go out on the falling edge
    always @(negedge clk)
    begin
        ccip_pkg::ccip_rx_t nxt;
        nxt = '0;
        if (rst_n)
        begin
            // Both bits set gives almost-full about a quarter of the time
            nxt.c0_almfull = (take_bits(2) == 8'd3);
            nxt.c1_almfull = (take_bits(2) == 8'd3);
            for (int i = 0; i < rd_due.size(); i++)
            begin
                if (rd_due[i] <= cycle)
                begin
                    nxt.c0.resp_valid = 1'b1;
                    nxt.c0.mdata      = rd_tag[i];
                    nxt.c0.data       = mem.exists(rd_addr[i]) ? mem[rd_addr[i]] : '0;
                    sent_addr         = rd_addr[i];
                    rd_addr.delete(i);
                    rd_tag.delete(i);
                    rd_due.delete(i);
                    break;
                end
            end
            for (int i = 0; i < wr_due.size(); i++)
            begin
                if (wr_due[i] <= cycle)
                begin
                    nxt.c1.resp_valid = 1'b1;
                    nxt.c1.mdata      = wr_tag[i];
                    wr_tag.delete(i);
                    wr_due.delete(i);
                    break;
                end
            end
        end
        rx_q <= nxt;
    end

endmodule

`default_nettype wire

//--- hdl/afu_top.sv
/* Top level of the copy AFU: the FIU shim feeds the CSR block and the copy engine.
   Only the FIU receive and transmit bundles leave this module. */
`timescale 1ns/1ps
`default_nettype none

module afu_top
(
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire ccip_pkg::ccip_rx_t fiu_rx,
    output ccip_pkg::ccip_tx_t      fiu_tx
);

    // Shim to consumers
    ccip_pkg::ccip_rx_t host_rx;
    ccip_pkg::c0_rx_t   mmio_req;

    // Consumers back to the shim
    ccip_pkg::c0_tx_t   host_c0_tx;
    ccip_pkg::c1_tx_t   host_c1_tx;
    ccip_pkg::c2_tx_t   mmio_c2_tx;

    // CSR block to engine and back
    ccip_pkg::dma_cfg_t cfg;
    logic               start;
    logic               busy;
    logic               done;

    ccip_split_mmio ccip_split_mmio_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .fiu_rx     (fiu_rx),
        .fiu_tx     (fiu_tx),
        .host_rx    (host_rx),
        .mmio_req   (mmio_req),
        .host_c0_tx (host_c0_tx),
        .host_c1_tx (host_c1_tx),
        .mmio_c2_tx (mmio_c2_tx)
    );

    mmio_csr mmio_csr_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .mmio_req (mmio_req),
        .c2_tx    (mmio_c2_tx),
        .cfg      (cfg),
        .start    (start),
        .busy     (busy),
        .done     (done)
    );

    dma_copy_engine dma_copy_engine_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .start   (start),
        .host_rx (host_rx),
        .c0_tx   (host_c0_tx),
        .c1_tx   (host_c1_tx),
        .busy    (busy),
        .done    (done)
    );

endmodule

`default_nettype wire

//--- hdl/ccip_split_mmio.sv
/* FIU-side shim: registers the receive channels once and hands MMIO requests and host
   memory responses to separate consumers, then merges their transmit channels. */
`timescale 1ns/1ps
`default_nettype none

module ccip_split_mmio
(
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire ccip_pkg::ccip_rx_t fiu_rx,
    output ccip_pkg::ccip_tx_t      fiu_tx,
    output ccip_pkg::ccip_rx_t      host_rx,
    output ccip_pkg::c0_rx_t        mmio_req,
    input  wire ccip_pkg::c0_tx_t   host_c0_tx,
    input  wire ccip_pkg::c1_tx_t   host_c1_tx,
    input  wire ccip_pkg::c2_tx_t   mmio_c2_tx
);

    ccip_pkg::c0_rx_t c0_q;
    ccip_pkg::c1_rx_t c1_q;

    // One-cycle slice on both receive channels
    always_ff @(posedge clk)
    begin
        c0_q <= fiu_rx.c0;
        c1_q <= fiu_rx.c1;
        if (!rst_n)
        begin
            c0_q.resp_valid    <= 1'b0;
            c0_q.mmio_rd_valid <= 1'b0;
            c0_q.mmio_wr_valid <= 1'b0;
            c1_q.resp_valid    <= 1'b0;
        end
    end

    // The memory side sees c0 beats only when they are read responses.
    // Almost-full comes straight from the FIU so the engine throttles in the same cycle
    always_comb
    begin
        host_rx                  = '0;
        host_rx.c0               = c0_q;
        host_rx.c0.mmio_rd_valid = 1'b0;
        host_rx.c0.mmio_wr_valid = 1'b0;
        host_rx.c1               = c1_q;
        host_rx.c0_almfull       = fiu_rx.c0_almfull;
        host_rx.c1_almfull       = fiu_rx.c1_almfull;
    end

    // The CSR side sees only MMIO reads and writes
    always_comb
    begin
        mmio_req            = c0_q;
        mmio_req.resp_valid = 1'b0;
    end

    // Each transmit channel has exactly one owner, so no arbitration is needed
    always_comb
    begin
        fiu_tx.c0 = host_c0_tx;
        fiu_tx.c1 = host_c1_tx;
        fiu_tx.c2 = mmio_c2_tx;
    end

endmodule

`default_nettype wire

//--- hdl/mmio_csr.sv
/* Control and status registers of the copy engine, reached by 64-bit MMIO.
   Software programs src, dst and lines, writes ctrl bit 0 and polls status. */
`timescale 1ns/1ps
`default_nettype none

`include "ccip_macros.svh"

module mmio_csr
(
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire ccip_pkg::c0_rx_t   mmio_req,
    output ccip_pkg::c2_tx_t        c2_tx,
    output ccip_pkg::dma_cfg_t      cfg,
    output logic                    start,
    input  wire logic               busy,
    input  wire logic               done
);

    localparam int DW = `CCIP_DATA_W;

    logic [`CCIP_DATA_W-1:0]      scratch_q;
    logic [`CCIP_LINE_ADDR_W-1:0] src_q;
    logic [`CCIP_LINE_ADDR_W-1:0] dst_q;
    logic [`CCIP_MDATA_W-1:0]     lines_q;
    logic                         done_q;
    logic [`CCIP_DATA_W-1:0]      rd_data;

    // A start is a ctrl write with bit 0 set while the engine is idle.
    // It stays combinational so the engine raises busy two cycles after the FIU write
    assign start = mmio_req.mmio_wr_valid
                && (mmio_req.mmio_addr == `CSR_CTRL)
                && mmio_req.data[0]
                && !busy;

    // Writable registers, narrowed to the width the engine uses
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            scratch_q <= '0;
            src_q     <= '0;
            dst_q     <= '0;
            lines_q   <= '0;
        end
        else if (mmio_req.mmio_wr_valid)
        begin
            case (mmio_req.mmio_addr)
                `CSR_SCRATCH: scratch_q <= mmio_req.data;
                `CSR_SRC:     src_q     <= mmio_req.data[`CCIP_LINE_ADDR_W-1:0];
                `CSR_DST:     dst_q     <= mmio_req.data[`CCIP_LINE_ADDR_W-1:0];
                `CSR_LINES:   lines_q   <= mmio_req.data[`CCIP_MDATA_W-1:0];
                default:      ;
            endcase
        end
    end

    // Sticky completion flag, cleared when a new run is accepted
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            done_q <= 1'b0;
        end
        else if (start)
        begin
            done_q <= 1'b0;
        end
        else if (done)
        begin
            done_q <= 1'b1;
        end
    end

    // Read mux. Ctrl and unmapped words read as zero
    always_comb
    begin
        case (mmio_req.mmio_addr)
            `CSR_AFU_ID:  rd_data = `AFU_ID_VALUE;
            `CSR_SCRATCH: rd_data = scratch_q;
            `CSR_SRC:     rd_data = DW'(src_q);
            `CSR_DST:     rd_data = DW'(dst_q);
            `CSR_LINES:   rd_data = DW'(lines_q);
            `CSR_STATUS:  rd_data = {{(DW-2){1'b0}}, done_q, busy};
            default:      rd_data = '0;
        endcase
    end

    // Read response goes out one cycle after the request reaches this block
    always_ff @(posedge clk)
    begin
        c2_tx.tid  <= mmio_req.tid;
        c2_tx.data <= rd_data;
        if (!rst_n)
        begin
            c2_tx.valid <= 1'b0;
        end
        else
        begin
            c2_tx.valid <= mmio_req.mmio_rd_valid;
        end
    end

    // Live register values feed the engine, which latches them on start
    always_comb
    begin
        cfg.src   = src_q;
        cfg.dst   = dst_q;
        cfg.lines = lines_q;
    end

endmodule

`default_nettype wire

//--- hdl/dma_copy_engine.sv
/* Line-copy engine: reads lines from src, buffers the returned data and writes each line
   to the same offset from dst. Started by a pulse from the CSR block. */
`timescale 1ns/1ps
`default_nettype none

`include "ccip_macros.svh"

module dma_copy_engine
(
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire ccip_pkg::dma_cfg_t cfg,
    input  wire logic               start,
    input  wire ccip_pkg::ccip_rx_t host_rx,
    output ccip_pkg::c0_tx_t        c0_tx,
    output ccip_pkg::c1_tx_t        c1_tx,
    output logic                    busy,
    output logic                    done
);

    localparam int AW    = `CCIP_LINE_ADDR_W;
    localparam int CNT_W = $clog2(`DMA_BUF_DEPTH + 1);

    ccip_pkg::dma_cfg_t     cfg_q;
    logic                   busy_q;
    logic                   start_ok;
    logic [`CCIP_MDATA_W-1:0] rd_idx_q;
    logic [`CCIP_MDATA_W-1:0] wr_rsp_q;
    logic [CNT_W-1:0]       rd_out_q;
    logic [CNT_W:0]         credit_used;
    logic                   credit_ok;
    logic                   rd_issue;
    logic                   wr_issue;
    ccip_pkg::dma_line_t    push_line;
    ccip_pkg::dma_line_t    head;
    logic                   fifo_empty;
    logic [CNT_W-1:0]       fifo_count;

    // A start that arrives during a run is dropped
    assign start_ok = start && !busy_q;

    // Every outstanding read owns a FIFO slot, so the buffer can never overflow
    assign credit_used = {1'b0, rd_out_q} + {1'b0, fifo_count};
    assign credit_ok   = credit_used < (CNT_W + 1)'(`DMA_BUF_DEPTH);

    // Requests are decided against this cycle's almost-full levels
    assign rd_issue = busy_q
                   && (rd_idx_q != cfg_q.lines)
                   && !host_rx.c0_almfull
                   && credit_ok;
    assign wr_issue = !fifo_empty && !host_rx.c1_almfull;

    // Run parameters are frozen for the whole run
    always_ff @(posedge clk)
    begin
        if (start_ok)
        begin
            cfg_q <= cfg;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy_q   <= 1'b0;
            done     <= 1'b0;
            rd_idx_q <= '0;
            wr_rsp_q <= '0;
            rd_out_q <= '0;
        end
        else
        begin
            done <= 1'b0;

            // Reads in flight: one more per request, one less per response
            case ({rd_issue, host_rx.c0.resp_valid})
                2'b10:   rd_out_q <= rd_out_q + 1'b1;
                2'b01:   rd_out_q <= rd_out_q - 1'b1;
                default: ;
            endcase

            if (start_ok)
            begin
                rd_idx_q <= '0;
                wr_rsp_q <= '0;
                // An empty run completes at once without touching the host
                busy_q   <= (cfg.lines != '0);
                done     <= (cfg.lines == '0);
            end
            else if (busy_q)
            begin
                if (rd_issue)
                begin
                    rd_idx_q <= rd_idx_q + 1'b1;
                end
                if (host_rx.c1.resp_valid)
                begin
                    wr_rsp_q <= wr_rsp_q + 1'b1;
                end
                // Write responses may come back in any order, only their number matters
                if (wr_rsp_q == cfg_q.lines)
                begin
                    busy_q <= 1'b0;
                    done   <= 1'b1;
                end
            end
        end
    end

    // The tag of a read carries its line index back with the data
    always_comb
    begin
        push_line.mdata = host_rx.c0.mdata;
        push_line.data  = host_rx.c0.data;
    end

    line_fifo #(
        .DEPTH(`DMA_BUF_DEPTH)
    ) line_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (host_rx.c0.resp_valid),
        .push_line (push_line),
        .pop       (wr_issue),
        .head      (head),
        .empty     (fifo_empty),
        .count     (fifo_count)
    );

    // Request channels are driven straight from the issue decisions
    always_comb
    begin
        c0_tx.valid = rd_issue;
        c0_tx.addr  = cfg_q.src + AW'(rd_idx_q);
        c0_tx.mdata = rd_idx_q;
        c1_tx.valid = wr_issue;
        c1_tx.addr  = cfg_q.dst + AW'(head.mdata);
        c1_tx.mdata = head.mdata;
        c1_tx.data  = head.data;
    end

    assign busy = busy_q;

endmodule

`default_nettype wire

//--- hdl/line_fifo.sv
/* Show-ahead FIFO of returned read lines with an occupancy count for credit tracking.
   A push into a full FIFO is dropped unless a pop frees a slot in the same cycle. */
`timescale 1ns/1ps
`default_nettype none

`include "ccip_macros.svh"

module line_fifo
#(
    parameter int DEPTH = `DMA_BUF_DEPTH
)
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  push,
    input  wire ccip_pkg::dma_line_t   push_line,
    input  wire logic                  pop,
    output ccip_pkg::dma_line_t        head,
    output logic                       empty,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    ccip_pkg::dma_line_t mem [DEPTH];
    logic [PTR_W-1:0]    wr_ptr_q;
    logic [PTR_W-1:0]    rd_ptr_q;
    logic [CNT_W-1:0]    count_q;
    logic                rd_en;
    logic                wr_en;

    // Pointers wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign rd_en = pop && !empty;
    assign wr_en = push && ((count_q != CNT_W'(DEPTH)) || rd_en);

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr_q] <= push_line;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (rd_en)
            begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    // Oldest line is always visible at the output
    assign head  = mem[rd_ptr_q];
    assign empty = (count_q == '0);
    assign count = count_q;

endmodule

`default_nettype wire

//--- hdl/ccip_pkg.sv
/* Packed channel structs of the FIU link, the copy configuration and the buffered line.
   Shared by the AFU RTL and the testbench through scoped names. */
`default_nettype none

`include "ccip_macros.svh"

package ccip_pkg;

    // Receive channel 0 carries host read responses and MMIO requests
    typedef struct packed {
        logic                          resp_valid;
        logic                          mmio_rd_valid;
        logic                          mmio_wr_valid;
        logic [`CCIP_MDATA_W-1:0]      mdata;
        logic [`CCIP_MMIO_ADDR_W-1:0]  mmio_addr;
        logic [`CCIP_TID_W-1:0]        tid;
        logic [`CCIP_DATA_W-1:0]       data;
    } c0_rx_t;

    // Receive channel 1 only acknowledges writes
    typedef struct packed {
        logic                          resp_valid;
        logic [`CCIP_MDATA_W-1:0]      mdata;
    } c1_rx_t;

    // Everything the FIU sends toward the AFU in one cycle
    typedef struct packed {
        c0_rx_t                        c0;
        c1_rx_t                        c1;
        logic                          c0_almfull;
        logic                          c1_almfull;
    } ccip_rx_t;

    // Line read request
    typedef struct packed {
        logic                          valid;
        logic [`CCIP_LINE_ADDR_W-1:0]  addr;
        logic [`CCIP_MDATA_W-1:0]      mdata;
    } c0_tx_t;

    // Line write request with its payload
    typedef struct packed {
        logic                          valid;
        logic [`CCIP_LINE_ADDR_W-1:0]  addr;
        logic [`CCIP_MDATA_W-1:0]      mdata;
        logic [`CCIP_DATA_W-1:0]       data;
    } c1_tx_t;

    // MMIO read response, matched to its request by tid
    typedef struct packed {
        logic                          valid;
        logic [`CCIP_TID_W-1:0]        tid;
        logic [`CCIP_DATA_W-1:0]       data;
    } c2_tx_t;

    typedef struct packed {
        c0_tx_t                        c0;
        c1_tx_t                        c1;
        c2_tx_t                        c2;
    } ccip_tx_t;

    // One returned read line waiting for its write
    typedef struct packed {
        logic [`CCIP_MDATA_W-1:0]      mdata;
        logic [`CCIP_DATA_W-1:0]       data;
    } dma_line_t;

    // Copy run parameters as programmed over MMIO
    typedef struct packed {
        logic [`CCIP_LINE_ADDR_W-1:0]  src;
        logic [`CCIP_LINE_ADDR_W-1:0]  dst;
        logic [`CCIP_MDATA_W-1:0]      lines;
    } dma_cfg_t;

endpackage

`default_nettype wire

//--- hdl/ccip_macros.svh
/* Widths, CSR word map and buffer sizing for the line-copy AFU.
   Include it in any file that needs one of these constants. */
`ifndef CCIP_MACROS_SVH
`define CCIP_MACROS_SVH

// Channel field widths of the reduced CCI-P model
`define CCIP_LINE_ADDR_W 42
`define CCIP_DATA_W      64
`define CCIP_MDATA_W     16
`define CCIP_MMIO_ADDR_W 16
`define CCIP_TID_W       9

// MMIO 64-bit word indices of the control registers
`define CSR_AFU_ID  `CCIP_MMIO_ADDR_W'd0
`define CSR_SCRATCH `CCIP_MMIO_ADDR_W'd1
`define CSR_SRC     `CCIP_MMIO_ADDR_W'd2
`define CSR_DST     `CCIP_MMIO_ADDR_W'd3
`define CSR_LINES   `CCIP_MMIO_ADDR_W'd4
`define CSR_CTRL    `CCIP_MMIO_ADDR_W'd5
`define CSR_STATUS  `CCIP_MMIO_ADDR_W'd6

`define AFU_ID_VALUE  64'h7c3a_91e0_4b5d_2f18
`define DMA_BUF_DEPTH 8

`endif
